/* design/mesh_node_cfg.svh */
`ifndef MESH_NODE_CFG_SVH
`define MESH_NODE_CFG_SVH

// Message framing
`define MN_MSG_W        32
`define MN_COORD_W      4

// Logic core I/O widths
`define MN_INPUTS       8
`define MN_OUTPUTS      8

// Instruction store geometry
`define MN_STORE_DEPTH  16
`define MN_STORE_ADDR_W 4
`define MN_INSTR_W      14

// Compass directions per node
`define MN_DIRS         4

`endif

/* design/mesh_node_pkg.sv */
`include "mesh_node_cfg.svh"

package mesh_node_pkg;

// Derived widths
localparam int PAYLOAD_W = `MN_MSG_W - 2 * `MN_COORD_W - 2;
localparam int COUNT_W   = `MN_STORE_ADDR_W + 1;
localparam int INDEX_W   = $clog2(`MN_INPUTS);
localparam int SRC_W     = $clog2(`MN_INPUTS + `MN_OUTPUTS);
localparam int DST_W     = $clog2(`MN_OUTPUTS);

// Node position in the mesh
typedef struct packed {
    logic [`MN_COORD_W-1:0] row;
    logic [`MN_COORD_W-1:0] column;
} node_id_t;

typedef enum logic [1:0] {
    MSG_LOAD,
    MSG_SIGNAL,
    MSG_CONTROL,
    MSG_OUTPUT
} msg_opcode_e;

typedef struct packed {
    node_id_t    target;
    msg_opcode_e opcode;
} msg_header_t;

typedef struct packed {
    msg_header_t          header;
    logic [PAYLOAD_W-1:0] payload;
} node_message_t;

// Two-input gates, INV and BUF read only source A
typedef enum logic [2:0] {
    GATE_AND,
    GATE_OR,
    GATE_XOR,
    GATE_NAND,
    GATE_NOR,
    GATE_XNOR,
    GATE_INV,
    GATE_BUF
} gate_op_e;

// Sources 0-7 are inputs, 8-15 are outputs
typedef struct packed {
    gate_op_e         op;
    logic [SRC_W-1:0] src_a;
    logic [SRC_W-1:0] src_b;
    logic [DST_W-1:0] dst;
} instr_t;

// Payload views, all padded up to PAYLOAD_W
typedef struct packed {
    logic [PAYLOAD_W-`MN_STORE_ADDR_W-`MN_INSTR_W-1:0] pad;
    logic [`MN_STORE_ADDR_W-1:0]                      addr;
    instr_t                                           instr;
} load_payload_t;

typedef struct packed {
    logic [PAYLOAD_W-INDEX_W-2:0] pad;
    logic [INDEX_W-1:0]           index;
    logic                         value;
} signal_payload_t;

typedef struct packed {
    logic [PAYLOAD_W-COUNT_W-2*`MN_COORD_W-1:0] pad;
    logic [COUNT_W-1:0]                         num_instr;
    node_id_t                                   target;
} control_payload_t;

typedef struct packed {
    logic [PAYLOAD_W-2*`MN_COORD_W-`MN_OUTPUTS-1:0] pad;
    node_id_t                                       source;
    logic [`MN_OUTPUTS-1:0]                         outputs;
} output_payload_t;

typedef enum logic [1:0] {
    DIR_NORTH = 2'd0,
    DIR_EAST  = 2'd1,
    DIR_SOUTH = 2'd2,
    DIR_WEST  = 2'd3
} direction_e;

endpackage : mesh_node_pkg

/* design/stream_arbiter.sv */
`timescale 1ns/100ps
`include "mesh_node_cfg.svh"

module stream_arbiter
    import mesh_node_pkg::*;
(
      input  logic                              i_clk
    , input  logic                              i_arst_n
    // Inbound streams, one per direction
    , input  node_message_t [`MN_DIRS-1:0]      i_inbound_data
    , input  logic          [`MN_DIRS-1:0]      i_inbound_valid
    , output logic          [`MN_DIRS-1:0]      o_inbound_ready
    // Merged stream
    , output node_message_t                     o_outbound_data
    , output logic                              o_outbound_valid
    , input  logic                              i_outbound_ready
);

// Round-robin pointer, first input to consider
logic [1:0] rr_ptr;
logic [1:0] grant_idx;
logic       grant_any;

// Search from the pointer upwards
// walking backwards so the nearest valid input wins
always_comb begin
    logic [1:0] idx;
    grant_idx = rr_ptr;
    grant_any = 1'b0;
    for (int i = `MN_DIRS - 1; i >= 0; i--) begin
        idx = rr_ptr + 2'(i);
        if (i_inbound_valid[idx]) begin
            grant_idx = idx;
            grant_any = 1'b1;
        end
    end
end

// Mux granted stream through
assign o_outbound_data  = i_inbound_data[grant_idx];
assign o_outbound_valid = grant_any;

// Only the granted input sees ready
always_comb begin
    o_inbound_ready = '0;
    if (grant_any) o_inbound_ready[grant_idx] = i_outbound_ready;
end

// Move past the granted input on each transfer
always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
        rr_ptr <= '0;
    end else if (grant_any && i_outbound_ready) begin
        rr_ptr <= grant_idx + 2'd1;
    end
end

// Never accept from two inputs in the same cycle
assert property (@(posedge i_clk) disable iff (!i_arst_n)
    $onehot0(o_inbound_ready));

endmodule : stream_arbiter

/* design/message_decoder.sv */
`timescale 1ns/100ps
`include "mesh_node_cfg.svh"

module message_decoder
    import mesh_node_pkg::*;
(
      input  logic                        i_clk
    , input  logic                        i_arst_n
    // Locally addressed messages
    , input  node_message_t               i_msg_data
    , input  logic                        i_msg_valid
    , output logic                        o_msg_ready
    // Instruction store write port
    , output logic [`MN_STORE_ADDR_W-1:0] o_wr_addr
    , output instr_t                      o_wr_data
    , output logic                        o_wr_en
    // Run state for the core
    , output logic [`MN_INPUTS-1:0]       o_inputs
    , output logic [COUNT_W-1:0]          o_num_instr
    , output node_id_t                    o_result_target
);

// Payload views
load_payload_t    load_view;
signal_payload_t  sig_view;
control_payload_t ctrl_view;
logic             msg_xfer;

assign load_view = i_msg_data.payload;
assign sig_view  = i_msg_data.payload;
assign ctrl_view = i_msg_data.payload;

// Every effect is a register update, so never stall
assign o_msg_ready = 1'b1;
assign msg_xfer    = i_msg_valid && o_msg_ready;

// ======================================================================
// Control state
// ======================================================================

always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
        o_wr_en         <= 1'b0;
        o_inputs        <= '0;
        o_num_instr     <= '0;
        o_result_target <= '0;
    end else begin
        o_wr_en <= 1'b0;
        if (msg_xfer) begin
            case (i_msg_data.header.opcode)
                MSG_LOAD: o_wr_en <= 1'b1;
                MSG_SIGNAL: o_inputs[sig_view.index] <= sig_view.value;
                MSG_CONTROL: begin
                    o_num_instr     <= ctrl_view.num_instr;
                    o_result_target <= ctrl_view.target;
                end
                // OUTPUT aimed at this node is dropped
                default: ;
            endcase
        end
    end
end

// Write address and data, qualified by o_wr_en
always_ff @(posedge i_clk) begin
    if (msg_xfer && i_msg_data.header.opcode == MSG_LOAD) begin
        o_wr_addr <= load_view.addr;
        o_wr_data <= load_view.instr;
    end
end

endmodule : message_decoder

/* design/instr_store.sv */
`timescale 1ns/100ps
`include "mesh_node_cfg.svh"

module instr_store
    import mesh_node_pkg::*;
(
      input  logic                        i_clk
    // Write port from the decoder
    , input  logic [`MN_STORE_ADDR_W-1:0] i_wr_addr
    , input  instr_t                      i_wr_data
    , input  logic                        i_wr_en
    // Read port from the core
    , input  logic [`MN_STORE_ADDR_W-1:0] i_rd_addr
    , input  logic                        i_rd_en
    , output instr_t                      o_rd_data
);

// Instruction RAM
instr_t mem [`MN_STORE_DEPTH];

always_ff @(posedge i_clk) begin
    if (i_wr_en) mem[i_wr_addr] <= i_wr_data;
end

// Registered read, one cycle latency
always_ff @(posedge i_clk) begin
    if (i_rd_en) o_rd_data <= mem[i_rd_addr];
end

endmodule : instr_store

/* design/logic_core.sv */
`timescale 1ns/100ps
`include "mesh_node_cfg.svh"

module logic_core
    import mesh_node_pkg::*;
(
      input  logic                        i_clk
    , input  logic                        i_arst_n
    // Node control
    , input  node_id_t                    i_node_id
    , input  logic                        i_trigger
    // Run parameters from the decoder
    , input  logic [`MN_INPUTS-1:0]       i_inputs
    , input  logic [COUNT_W-1:0]          i_num_instr
    , input  node_id_t                    i_result_target
    // Instruction fetch
    , output logic [`MN_STORE_ADDR_W-1:0] o_rd_addr
    , output logic                        o_rd_en
    , input  instr_t                      i_rd_data
    // Result stream
    , output node_message_t               o_msg_data
    , output logic                        o_msg_valid
    , input  logic                        i_msg_ready
    , output logic                        o_idle
);

typedef enum logic [1:0] {
    IDLE,
    FETCH,
    EXEC,
    EMIT
} core_state_e;

core_state_e            state;
logic [COUNT_W-1:0]     instr_idx;
logic [COUNT_W-1:0]     next_idx;
logic [`MN_OUTPUTS-1:0] outputs_q;
logic                   gate_a, gate_b, gate_result;
output_payload_t        result_view;

// Operand is an input bit or an earlier output bit
function automatic logic pick_src(
    logic [SRC_W-1:0] src, logic [`MN_INPUTS-1:0] ins, logic [`MN_OUTPUTS-1:0] outs
);
    return src[SRC_W-1] ? outs[src[DST_W-1:0]] : ins[src[INDEX_W-1:0]];
endfunction

function automatic logic eval_gate(gate_op_e op, logic a, logic b);
    case (op)
        GATE_AND:  return a & b;
        GATE_OR:   return a | b;
        GATE_XOR:  return a ^ b;
        GATE_NAND: return ~(a & b);
        GATE_NOR:  return ~(a | b);
        GATE_XNOR: return ~(a ^ b);
        GATE_INV:  return ~a;
        default:   return a;
    endcase
endfunction

// ======================================================================
// Fetch and execute
// ======================================================================

assign next_idx = instr_idx + 1'b1;

// Fetch next while the current one executes
assign o_rd_en   = (state == FETCH) || (state == EXEC && next_idx < i_num_instr);
assign o_rd_addr = (state == EXEC) ? next_idx[`MN_STORE_ADDR_W-1:0]
                                   : instr_idx[`MN_STORE_ADDR_W-1:0];

assign gate_a      = pick_src(i_rd_data.src_a, i_inputs, outputs_q);
assign gate_b      = pick_src(i_rd_data.src_b, i_inputs, outputs_q);
assign gate_result = eval_gate(i_rd_data.op, gate_a, gate_b);

always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
        state     <= IDLE;
        instr_idx <= '0;
        outputs_q <= '0;
    end else begin
        case (state)
            IDLE: if (i_trigger) begin
                outputs_q <= '0;
                instr_idx <= '0;
                state     <= (i_num_instr == '0) ? EMIT : FETCH;
            end
            FETCH: state <= EXEC;
            EXEC: begin
                outputs_q[i_rd_data.dst] <= gate_result;
                instr_idx                <= next_idx;
                if (next_idx == i_num_instr) state <= EMIT;
            end
            // Hold the result until it is taken
            EMIT: if (i_msg_ready) state <= IDLE;
            default: state <= IDLE;
        endcase
    end
end

// ======================================================================
// Result message
// ======================================================================

always_comb begin
    result_view         = '0;
    result_view.source  = i_node_id;
    result_view.outputs = outputs_q;
end

assign o_msg_data.header.target = i_result_target;
assign o_msg_data.header.opcode = MSG_OUTPUT;
assign o_msg_data.payload       = result_view;
assign o_msg_valid              = (state == EMIT);
assign o_idle                   = (state == IDLE);

// Result offer is never withdrawn or altered before it transfers
assert property (@(posedge i_clk) disable iff (!i_arst_n)
    o_msg_valid && !i_msg_ready |=> o_msg_valid && $stable(o_msg_data));

endmodule : logic_core

/* design/route_distributor.sv */
`timescale 1ns/100ps
`include "mesh_node_cfg.svh"

module route_distributor
    import mesh_node_pkg::*;
(
      input  logic                         i_clk
    , input  logic                         i_arst_n
    , input  node_id_t                     i_node_id
    // Bypass traffic from the arbiter, higher priority
    , input  node_message_t                i_bypass_data
    , input  logic                         i_bypass_valid
    , output logic                         o_bypass_ready
    // Result traffic from the core
    , input  node_message_t                i_result_data
    , input  logic                         i_result_valid
    , output logic                         o_result_ready
    // Outbound streams
    , output node_message_t [`MN_DIRS-1:0] o_outbound_data
    , output logic          [`MN_DIRS-1:0] o_outbound_valid
    , input  logic          [`MN_DIRS-1:0] i_outbound_ready
    , input  logic          [`MN_DIRS-1:0] i_outbound_present
    , output logic                         o_idle
);

node_message_t       sel_data;
logic                sel_valid;
direction_e          sel_dir;
logic [`MN_DIRS-1:0] can_accept;
logic                load;

// Bypass wins over result
assign sel_data  = i_bypass_valid ? i_bypass_data : i_result_data;
assign sel_valid = i_bypass_valid || i_result_valid;

// Pick direction from the target, with clockwise fallback
always_comb begin
    node_id_t tgt;
    tgt = sel_data.header.target;
    if (tgt.row < i_node_id.row)
        sel_dir = i_outbound_present[DIR_NORTH] ? DIR_NORTH : DIR_EAST;
    else if (tgt.row > i_node_id.row)
        sel_dir = i_outbound_present[DIR_SOUTH] ? DIR_SOUTH : DIR_WEST;
    else if (tgt.column < i_node_id.column)
        sel_dir = i_outbound_present[DIR_WEST] ? DIR_WEST : DIR_NORTH;
    else
        sel_dir = i_outbound_present[DIR_EAST] ? DIR_EAST : DIR_SOUTH;
end

// Slot free, or emptying this cycle
assign can_accept     = ~o_outbound_valid | i_outbound_ready;
assign load           = sel_valid && can_accept[sel_dir];
assign o_bypass_ready = can_accept[sel_dir];
assign o_result_ready = !i_bypass_valid && can_accept[sel_dir];

// One holding register per direction
always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
        o_outbound_valid <= '0;
    end else begin
        for (int d = 0; d < `MN_DIRS; d++) begin
            if (load && sel_dir == direction_e'(d))
                o_outbound_valid[d] <= 1'b1;
            else if (i_outbound_ready[d])
                o_outbound_valid[d] <= 1'b0;
        end
    end
end

always_ff @(posedge i_clk) begin
    if (load) o_outbound_data[sel_dir] <= sel_data;
end

assign o_idle = ~|o_outbound_valid;

// Stalled outbound data holds until taken
for (genvar d = 0; d < `MN_DIRS; d++) begin : g_hold
    assert property (@(posedge i_clk) disable iff (!i_arst_n)
        o_outbound_valid[d] && !i_outbound_ready[d]
        |=> o_outbound_valid[d] && $stable(o_outbound_data[d]));
end

endmodule : route_distributor

/* design/mesh_node.sv */
`timescale 1ns/100ps
`include "mesh_node_cfg.svh"

module mesh_node
    import mesh_node_pkg::*;
(
      input  logic                         i_clk
    , input  logic                         i_arst_n
    // Node control
    , input  node_id_t                     i_node_id
    , input  logic                         i_trigger
    , output logic                         o_idle
    // Inbound streams
    , input  node_message_t [`MN_DIRS-1:0] i_inbound_data
    , input  logic          [`MN_DIRS-1:0] i_inbound_valid
    , output logic          [`MN_DIRS-1:0] o_inbound_ready
    // Outbound streams
    , output node_message_t [`MN_DIRS-1:0] o_outbound_data
    , output logic          [`MN_DIRS-1:0] o_outbound_valid
    , input  logic          [`MN_DIRS-1:0] i_outbound_ready
    , input  logic          [`MN_DIRS-1:0] i_outbound_present
);

// Arbiter output and local/bypass split
node_message_t arb_data;
logic          arb_valid, arb_ready, arb_match;
logic          dcd_valid, dcd_ready;
logic          byp_valid, byp_ready;

// Store write and read ports
logic [`MN_STORE_ADDR_W-1:0] wr_addr, rd_addr;
instr_t                      wr_data, rd_data;
logic                        wr_en, rd_en;

// Run parameters and result stream
logic [`MN_INPUTS-1:0] core_inputs;
logic [COUNT_W-1:0]    num_instr;
node_id_t              result_target;
node_message_t         res_data;
logic                  res_valid, res_ready;
logic                  core_idle, dist_idle;

// ======================================================================
// Inbound arbitration and address match
// ======================================================================

stream_arbiter u_arbiter (
      .i_clk            ( i_clk           )
    , .i_arst_n         ( i_arst_n        )
    , .i_inbound_data   ( i_inbound_data  )
    , .i_inbound_valid  ( i_inbound_valid )
    , .o_inbound_ready  ( o_inbound_ready )
    , .o_outbound_data  ( arb_data        )
    , .o_outbound_valid ( arb_valid       )
    , .i_outbound_ready ( arb_ready       )
);

// One compare steers both valid and ready
assign arb_match = (arb_data.header.target == i_node_id);
assign dcd_valid = arb_valid && arb_match;
assign byp_valid = arb_valid && !arb_match;
assign arb_ready = arb_match ? dcd_ready : byp_ready;

// ======================================================================
// Decode, store and core
// ======================================================================

message_decoder u_decoder (
      .i_clk           ( i_clk         )
    , .i_arst_n        ( i_arst_n      )
    , .i_msg_data      ( arb_data      )
    , .i_msg_valid     ( dcd_valid     )
    , .o_msg_ready     ( dcd_ready     )
    , .o_wr_addr       ( wr_addr       )
    , .o_wr_data       ( wr_data       )
    , .o_wr_en         ( wr_en         )
    , .o_inputs        ( core_inputs   )
    , .o_num_instr     ( num_instr     )
    , .o_result_target ( result_target )
);

instr_store u_store (
      .i_clk     ( i_clk   )
    , .i_wr_addr ( wr_addr )
    , .i_wr_data ( wr_data )
    , .i_wr_en   ( wr_en   )
    , .i_rd_addr ( rd_addr )
    , .i_rd_en   ( rd_en   )
    , .o_rd_data ( rd_data )
);

logic_core u_core (
      .i_clk           ( i_clk         )
    , .i_arst_n        ( i_arst_n      )
    , .i_node_id       ( i_node_id     )
    , .i_trigger       ( i_trigger     )
    , .i_inputs        ( core_inputs   )
    , .i_num_instr     ( num_instr     )
    , .i_result_target ( result_target )
    , .o_rd_addr       ( rd_addr       )
    , .o_rd_en         ( rd_en         )
    , .i_rd_data       ( rd_data       )
    , .o_msg_data      ( res_data      )
    , .o_msg_valid     ( res_valid     )
    , .i_msg_ready     ( res_ready     )
    , .o_idle          ( core_idle     )
);

// ======================================================================
// Outbound distribution
// ======================================================================

route_distributor u_distributor (
      .i_clk              ( i_clk              )
    , .i_arst_n           ( i_arst_n           )
    , .i_node_id          ( i_node_id          )
    , .i_bypass_data      ( arb_data           )
    , .i_bypass_valid     ( byp_valid          )
    , .o_bypass_ready     ( byp_ready          )
    , .i_result_data      ( res_data           )
    , .i_result_valid     ( res_valid          )
    , .o_result_ready     ( res_ready          )
    , .o_outbound_data    ( o_outbound_data    )
    , .o_outbound_valid   ( o_outbound_valid   )
    , .i_outbound_ready   ( i_outbound_ready   )
    , .i_outbound_present ( i_outbound_present )
    , .o_idle             ( dist_idle          )
);

// Idle once everything has drained and nothing is waiting
always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
        o_idle <= 1'b0;
    end else begin
        o_idle <= core_idle && dist_idle && !(|i_inbound_valid);
    end
end

endmodule : mesh_node

/* dv/mesh_node_props.sv */
`timescale 1ns/100ps
`include "mesh_node_cfg.svh"

module mesh_node_props
    import mesh_node_pkg::*;
(
      input  logic                         i_clk
    , input  logic                         i_arst_n
    , input  logic                         i_idle
    // Inbound side, for fairness
    , input  logic          [`MN_DIRS-1:0] i_inbound_valid
    , input  logic          [`MN_DIRS-1:0] i_inbound_ready
    // Outbound side and the model's prediction
    , input  node_message_t [`MN_DIRS-1:0] i_outbound_data
    , input  logic          [`MN_DIRS-1:0] i_outbound_valid
    , input  logic          [`MN_DIRS-1:0] i_outbound_ready
    , input  node_message_t [`MN_DIRS-1:0] i_exp_data
    , input  logic          [`MN_DIRS-1:0] i_exp_valid
    , output int                           o_errors
);

// Transfers a valid port has waited through
logic [2:0] starve [`MN_DIRS];

initial o_errors = 0;

// Clean state right after reset release
assert property (@(posedge i_clk) $rose(i_arst_n) |-> i_outbound_valid == '0 ##1 i_idle)
    else begin
        $display("Node not idle with empty outputs after reset at %0t", $time);
        o_errors++;
    end

// ======================================================================
// Per-direction outbound checks
// ======================================================================

for (genvar d = 0; d < `MN_DIRS; d++) begin : g_dir
    // Every transfer was predicted
    assert property (@(posedge i_clk) disable iff (!i_arst_n)
        i_outbound_valid[d] && i_outbound_ready[d] |-> i_exp_valid[d])
        else begin
            $display("Unexpected message on outbound %0d at %0t", d, $time);
            o_errors++;
        end

    // Payload and header as predicted
    assert property (@(posedge i_clk) disable iff (!i_arst_n)
        i_outbound_valid[d] && i_outbound_ready[d] |-> i_outbound_data[d] == i_exp_data[d])
        else begin
            $display("Mismatch at %0t: o_outbound_data[%0d] expected %h actual %h", $time, d,
                     $sampled(i_exp_data[d]), $sampled(i_outbound_data[d]));
            o_errors++;
        end

    // Stalled stream keeps its offer
    assert property (@(posedge i_clk) disable iff (!i_arst_n)
        i_outbound_valid[d] && !i_outbound_ready[d]
        |=> i_outbound_valid[d] && $stable(i_outbound_data[d]))
        else begin
            $display("Outbound %0d dropped or changed a stalled message at %0t", d, $time);
            o_errors++;
        end

    // Count grants to others while this port waits
    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            starve[d] <= '0;
        end else if (!i_inbound_valid[d] || i_inbound_ready[d]) begin
            starve[d] <= '0;
        end else if (|(i_inbound_valid & i_inbound_ready)) begin
            starve[d] <= starve[d] + 3'd1;
        end
    end

    assert property (@(posedge i_clk) disable iff (!i_arst_n) starve[d] < 3'd4)
        else begin
            $display("Inbound %0d starved for four transfers at %0t", d, $time);
            o_errors++;
        end
end

endmodule : mesh_node_props

/* dv/mesh_node_tb.sv */
`timescale 1ns/100ps
`include "mesh_node_cfg.svh"

module mesh_node_tb
    import mesh_node_pkg::*;
();

localparam int MAX_CYCLES = 4000;
localparam int PROG_LEN   = 12;

logic                         i_clk;
logic                         i_arst_n;
node_id_t                     node_id;
logic                         trigger;
logic                         o_idle;
node_message_t [`MN_DIRS-1:0] inbound_data;
logic          [`MN_DIRS-1:0] inbound_valid;
logic          [`MN_DIRS-1:0] o_inbound_ready;
node_message_t [`MN_DIRS-1:0] o_outbound_data;
logic          [`MN_DIRS-1:0] o_outbound_valid;
logic          [`MN_DIRS-1:0] outbound_ready;
logic          [`MN_DIRS-1:0] outbound_present;

// Reference model state
node_message_t                exp_q [`MN_DIRS][$];
node_message_t [`MN_DIRS-1:0] exp_data;
logic          [`MN_DIRS-1:0] exp_valid;
int                           errors;
int                           cycles;
int                           tests;
logic [31:0]                  seed;
logic                         rand_ready;

mesh_node mesh_node_inst (
      .i_clk              ( i_clk            )
    , .i_arst_n           ( i_arst_n         )
    , .i_node_id          ( node_id          )
    , .i_trigger          ( trigger          )
    , .o_idle             ( o_idle           )
    , .i_inbound_data     ( inbound_data     )
    , .i_inbound_valid    ( inbound_valid    )
    , .o_inbound_ready    ( o_inbound_ready  )
    , .o_outbound_data    ( o_outbound_data  )
    , .o_outbound_valid   ( o_outbound_valid )
    , .i_outbound_ready   ( outbound_ready   )
    , .i_outbound_present ( outbound_present )
);

mesh_node_props props_inst (
      .i_clk            ( i_clk            )
    , .i_arst_n         ( i_arst_n         )
    , .i_idle           ( o_idle           )
    , .i_inbound_valid  ( inbound_valid    )
    , .i_inbound_ready  ( o_inbound_ready  )
    , .i_outbound_data  ( o_outbound_data  )
    , .i_outbound_valid ( o_outbound_valid )
    , .i_outbound_ready ( outbound_ready   )
    , .i_exp_data       ( exp_data         )
    , .i_exp_valid      ( exp_valid        )
    , .o_errors         ( errors           )
);

// 8 ns clock
always #4 i_clk = ~i_clk;

function automatic logic [31:0] lcg_next();
    seed = seed * 32'd1664525 + 32'd1013904223;
    return seed;
endfunction

// Direction choice with clockwise fallback
function automatic int route_dir(node_id_t tgt);
    if (tgt.row < node_id.row)
        return outbound_present[DIR_NORTH] ? DIR_NORTH : DIR_EAST;
    if (tgt.row > node_id.row)
        return outbound_present[DIR_SOUTH] ? DIR_SOUTH : DIR_WEST;
    if (tgt.column < node_id.column)
        return outbound_present[DIR_WEST] ? DIR_WEST : DIR_NORTH;
    return outbound_present[DIR_EAST] ? DIR_EAST : DIR_SOUTH;
endfunction

// Target whose first route choice is direction d
function automatic node_id_t target_toward(int d);
    node_id_t t;
    t = node_id;
    case (direction_e'(d))
        DIR_NORTH: t.row    = node_id.row - 4'd1;
        DIR_EAST:  t.column = node_id.column + 4'd1;
        DIR_SOUTH: t.row    = node_id.row + 4'd1;
        default:   t.column = node_id.column - 4'd1;
    endcase
    return t;
endfunction

function automatic logic gate_model(gate_op_e op, logic a, logic b);
    case (op)
        GATE_AND:  return a & b;
        GATE_OR:   return a | b;
        GATE_XOR:  return a ^ b;
        GATE_NAND: return !(a & b);
        GATE_NOR:  return !(a | b);
        GATE_XNOR: return a == b;
        GATE_INV:  return !a;
        default:   return a;
    endcase
endfunction

// Random message for some other node
function automatic node_message_t random_bypass();
    node_message_t m;
    m = lcg_next();
    if (m.header.target == node_id) m.header.target.column = ~node_id.column;
    return m;
endfunction

// Pop transferred messages, expose queue heads to the checker
always @(posedge i_clk) begin
    for (int d = 0; d < `MN_DIRS; d++) begin
        if (o_outbound_valid[d] && outbound_ready[d] && exp_q[d].size() > 0)
            void'(exp_q[d].pop_front());
        exp_valid[d] <= exp_q[d].size() > 0;
        if (exp_q[d].size() > 0) exp_data[d] <= exp_q[d][0];
    end
end

// Optional random back-pressure
always @(posedge i_clk) begin
    if (rand_ready) outbound_ready <= 4'(lcg_next() >> 28);
    else outbound_ready <= '1;
end

always @(posedge i_clk) begin
    cycles++;
    if (cycles >= MAX_CYCLES) begin
        $display("Timeout after %0d cycles, a test did not finish", cycles);
        $display("** FAIL **");
        $finish;
    end
end

// Offer on one port and hold until taken
task automatic send_msg(input int port, input node_message_t msg);
    @(posedge i_clk);
    inbound_data[port]  <= msg;
    inbound_valid[port] <= 1'b1;
    do @(negedge i_clk); while (!o_inbound_ready[port]);
    @(posedge i_clk);
    inbound_valid[port] <= 1'b0;
endtask

task automatic send_bypass(input node_message_t msg);
    exp_q[route_dir(msg.header.target)].push_back(msg);
    send_msg(int'(lcg_next() >> 30), msg);
endtask

// Wait for empty predictions and an idle node
task automatic drain();
    int pending;
    do begin
        @(negedge i_clk);
        pending = 0;
        for (int d = 0; d < `MN_DIRS; d++) pending += exp_q[d].size();
    end while (pending != 0 || !o_idle);
endtask

task automatic report_test(input string name, input int err_before);
    tests++;
    $display("test %-12s errors %0d", name, errors - err_before);
endtask

// ======================================================================
// Tests
// ======================================================================

task automatic program_and_run();
    instr_t           prog [PROG_LEN];
    logic [7:0]       ins;
    logic [7:0]       outs;
    logic             a, b;
    logic [31:0]      r;
    node_message_t    m;
    load_payload_t    lp;
    signal_payload_t  sp;
    control_payload_t cp;
    output_payload_t  op;
    for (int i = 0; i < PROG_LEN; i++) begin
        r = lcg_next();
        prog[i].op    = gate_op_e'(r[31:29]);
        prog[i].src_a = r[27:24];
        prog[i].src_b = r[23:20];
        prog[i].dst   = r[18:16];
        lp = '0;
        lp.addr  = 4'(i);
        lp.instr = prog[i];
        m = '0;
        m.header.target = node_id;
        m.header.opcode = MSG_LOAD;
        m.payload       = lp;
        send_msg(int'(r[1:0]), m);
    end
    ins = 8'(lcg_next() >> 24);
    for (int k = 0; k < `MN_INPUTS; k++) begin
        sp = '0;
        sp.index = 3'(k);
        sp.value = ins[k];
        m.header.opcode = MSG_SIGNAL;
        m.payload       = sp;
        send_msg(k % `MN_DIRS, m);
    end
    cp = '0;
    cp.num_instr = 5'(PROG_LEN);
    cp.target    = '{row: 4'd2, column: 4'd9};
    m.header.opcode = MSG_CONTROL;
    m.payload       = cp;
    send_msg(0, m);
    // Sequential gate evaluation from cleared outputs
    outs = '0;
    for (int i = 0; i < PROG_LEN; i++) begin
        a = prog[i].src_a[3] ? outs[prog[i].src_a[2:0]] : ins[prog[i].src_a[2:0]];
        b = prog[i].src_b[3] ? outs[prog[i].src_b[2:0]] : ins[prog[i].src_b[2:0]];
        outs[prog[i].dst] = gate_model(prog[i].op, a, b);
    end
    op = '0;
    op.source  = node_id;
    op.outputs = outs;
    m.header.target = cp.target;
    m.header.opcode = MSG_OUTPUT;
    m.payload       = op;
    exp_q[route_dir(cp.target)].push_back(m);
    @(posedge i_clk);
    trigger <= 1'b1;
    @(posedge i_clk);
    trigger <= 1'b0;
    drain();
endtask

// All four ports offer local messages at once
task automatic fairness_run();
    node_message_t m;
    int            count;
    m = '0;
    m.header.target = node_id;
    m.header.opcode = MSG_OUTPUT;
    @(posedge i_clk);
    for (int p = 0; p < `MN_DIRS; p++) inbound_data[p] <= m;
    inbound_valid <= '1;
    count = 0;
    do begin
        @(negedge i_clk);
        if (|o_inbound_ready) count++;
    end while (count < 16);
    @(posedge i_clk);
    inbound_valid <= '0;
    drain();
endtask

initial begin
    int err_before;
    node_message_t m;
    i_clk            = 1'b0;
    i_arst_n         = 1'b0;
    node_id          = '{row: 4'd5, column: 4'd5};
    trigger          = 1'b0;
    inbound_data     = '0;
    inbound_valid    = '0;
    outbound_ready   = '1;
    outbound_present = '1;
    exp_data         = '0;
    exp_valid        = '0;
    cycles           = 0;
    tests            = 0;
    seed             = 32'h87e;
    rand_ready       = 1'b0;

    repeat (3) @(posedge i_clk);
    i_arst_n <= 1'b1;

    err_before = errors;
    drain();
    report_test("reset_idle", err_before);

    err_before = errors;
    for (int i = 0; i < 16; i++) begin
        m = random_bypass();
        // First few aim at each direction in turn
        if (i < `MN_DIRS) m.header.target = target_toward(i);
        send_bypass(m);
    end
    drain();
    report_test("bypass", err_before);

    // Knock out each direction in turn
    err_before = errors;
    for (int d = 0; d < `MN_DIRS; d++) begin
        @(posedge i_clk);
        outbound_present <= ~(4'b1 << d);
        // New mask is in place before any prediction
        @(negedge i_clk);
        for (int i = 0; i < 6; i++) begin
            m = random_bypass();
            if (i < 3) m.header.target = target_toward(d);
            send_bypass(m);
        end
        drain();
    end
    @(posedge i_clk);
    outbound_present <= '1;
    report_test("fallback", err_before);

    err_before = errors;
    program_and_run();
    report_test("program_run", err_before);

    err_before = errors;
    rand_ready = 1'b1;
    for (int i = 0; i < 24; i++) send_bypass(random_bypass());
    drain();
    rand_ready = 1'b0;
    report_test("backpressure", err_before);

    err_before = errors;
    fairness_run();
    report_test("fairness", err_before);

    $display("tests %0d errors %0d", tests, errors);
    if (errors == 0) begin
        $display("** PASS **");
    end else begin
        $display("** FAIL **");
    end
    $finish;
end

endmodule : mesh_node_tb

/* vlog.f */
+incdir+design
design/mesh_node_pkg.sv
design/stream_arbiter.sv
design/message_decoder.sv
design/instr_store.sv
design/logic_core.sv
design/route_distributor.sv
design/mesh_node.sv
dv/mesh_node_props.sv
dv/mesh_node_tb.sv

/* run.sh */
#!/bin/sh
# Build and run the mesh node testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal \
    -f vlog.f \
    --top-module mesh_node_tb \
    -o Vmesh_node_tb

./obj_dir/Vmesh_node_tb > sim.log 2>&1 || true
cat sim.log

if grep -q '\*\* FAIL \*\*' sim.log; then
    exit 1
fi
if ! grep -q '\*\* PASS \*\*' sim.log; then
    echo "Simulation ended without a result line"
    exit 1
fi
exit 0
